// File: project.f
+incdir+logic
logic/ll_pkg.sv
logic/ll_link_if.sv
logic/ll_auto_sync.sv
logic/ll_transmit.sv
logic/ll_receive.sv
logic/ll_phy_concat.sv
logic/st_link_slave_top.sv
verif/st_link_properties.sv
verif/st_link_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the link testbench with Verilator, pass only on the success line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module st_link_tb -o st_link_sim \
  && ./obj_dir/st_link_sim | tee /dev/stderr | grep -qx "TEST OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verif/st_link_tb.sv
`timescale 1ns/1ps
`include "ll_defs.svh"

module st_link_tb;

  localparam int N_WORDS      = 40;
  localparam int TIMEOUT      = 400;
  localparam int STALL_WINDOW = 40;
  localparam int DLY_X        = 12;
  localparam int DLY_Y        = 6;
  localparam int DLY_Z        = 5;
  localparam ll_pkg::ll_cred_t INIT_CREDIT = 4'd5;

  logic                  clk_wr = 1'b0;
  logic                  rst_n;
  logic                  tx_online;
  logic                  rx_online;
  ll_pkg::ll_cred_t      init_s2m_credit;
  logic [`LL_DLY_W-1:0]  delay_x_value;
  logic [`LL_DLY_W-1:0]  delay_y_value;
  logic [`LL_DLY_W-1:0]  delay_z_value;
  logic [`LL_LANE_W-1:0] tx_phy0;
  logic [`LL_LANE_W-1:0] tx_phy1;
  ll_pkg::ll_data_t      user_m2s_tdata;
  logic                  user_m2s_tvalid;
  logic                  user_m2s_tready;
  logic                  user_m2s_enable;
  ll_pkg::ll_data_t      user_s2m_tdata;
  logic                  user_s2m_tvalid;
  logic                  user_s2m_tready;
  ll_pkg::ll_rx_status_t rx_status;
  ll_pkg::ll_tx_status_t tx_status;

  logic [31:0]      lfsr_state = 32'h1bc15083;
  ll_pkg::ll_data_t sent_q[$];
  int               accepted = 0;
  int               received = 0;

  always #50 clk_wr = ~clk_wr;

  // tx lanes looped straight back into rx
  st_link_slave_top DUT (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .init_s2m_credit     (init_s2m_credit),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_phy0             (tx_phy0),
    .tx_phy1             (tx_phy1),
    .rx_phy0             (tx_phy0),
    .rx_phy1             (tx_phy1),
    .user_m2s_tdata      (user_m2s_tdata),
    .user_m2s_tvalid     (user_m2s_tvalid),
    .user_m2s_tready     (user_m2s_tready),
    .user_m2s_enable     (user_m2s_enable),
    .user_s2m_tdata      (user_s2m_tdata),
    .user_s2m_tvalid     (user_s2m_tvalid),
    .user_s2m_tready     (user_s2m_tready),
    .rx_m2s_debug_status (rx_status),
    .tx_s2m_debug_status (tx_status)
  );

  bind st_link_slave_top st_link_properties props (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .user_s2m_tdata  (user_s2m_tdata),
    .user_s2m_tvalid (user_s2m_tvalid),
    .user_s2m_tready (user_s2m_tready),
    .user_m2s_tdata  (user_m2s_tdata),
    .user_m2s_tvalid (user_m2s_tvalid),
    .user_m2s_tready (user_m2s_tready)
  );

  ////////////////////
  // Helpers

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    fail_now($sformatf("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp));
  endtask

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic ll_pkg::ll_data_t draw_word();
    ll_pkg::ll_data_t w;
    w = '0;
    for (int i = 0; i < `LL_DATA_W; i++) begin
      w = {w[`LL_DATA_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return w;
  endfunction

  // Holds the offered word until the beat, then drops valid
  task automatic wait_accept();
    int waited;
    waited = 0;
    @(negedge clk_wr);
    while (!user_s2m_tready) begin
      waited++;
      assert (waited < TIMEOUT) else fail_now("Timeout waiting for user_s2m_tready");
      @(negedge clk_wr);
    end
    @(posedge clk_wr);
    #1;
    sent_q.push_back(user_s2m_tdata);
    accepted++;
    user_s2m_tvalid = 1'b0;
  endtask

  task automatic send_word(input ll_pkg::ll_data_t w);
    user_s2m_tdata  = w;
    user_s2m_tvalid = 1'b1;
    wait_accept();
  endtask

  // Keeps a word on offer for a fixed window and counts the beats
  task automatic offer_window(input int cycles, output int beats);
    logic beat;
    beats = 0;
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk_wr);
      beat = user_s2m_tready;
      @(posedge clk_wr);
      #1;
      if (beat) begin
        sent_q.push_back(user_s2m_tdata);
        accepted++;
        beats++;
        user_s2m_tdata = draw_word();
      end
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (sent_q.size() != 0) begin
      waited++;
      assert (waited < TIMEOUT) else fail_now("Timeout waiting for sent words on M2S");
      @(posedge clk_wr);
      #1;
    end
  endtask

  task automatic wait_credit_back();
    int waited;
    waited = 0;
    while (tx_status.credit != INIT_CREDIT) begin
      waited++;
      assert (waited < TIMEOUT) else fail_now("Timeout waiting for all S2M credits to return");
      @(posedge clk_wr);
      #1;
    end
  endtask

  ////////////////////
  // M2S scoreboard

  always @(negedge clk_wr) begin
    ll_pkg::ll_data_t expected;
    if (rst_n && user_m2s_tvalid && user_m2s_tready) begin
      assert (sent_q.size() != 0) else fail_now("Word arrived on M2S with none outstanding");
      expected = sent_q.pop_front();
      assert (user_m2s_tdata == expected)
        else fail_value("user_m2s_tdata", user_m2s_tdata, expected);
      received++;
    end
  end

  initial begin
    int beats;
    int cycles;
    int strobes;
    rst_n           = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    init_s2m_credit = INIT_CREDIT;
    delay_x_value   = `LL_DLY_W'(DLY_X);
    delay_y_value   = `LL_DLY_W'(DLY_Y);
    delay_z_value   = `LL_DLY_W'(DLY_Z);
    user_m2s_tready = 1'b0;
    user_s2m_tdata  = '0;
    user_s2m_tvalid = 1'b0;
    repeat (2) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;

    // Idle state out of reset
    @(negedge clk_wr);
    assert (!user_s2m_tready) else fail_value("user_s2m_tready", user_s2m_tready, 0);
    assert (!user_m2s_enable) else fail_value("user_m2s_enable", user_m2s_enable, 0);
    assert (!user_m2s_tvalid) else fail_value("user_m2s_tvalid", user_m2s_tvalid, 0);
    assert (tx_phy0[`LL_LANE_STB:`LL_LANE_CRED] == 3'b000)
      else fail_value("tx_phy0 control bits", tx_phy0[`LL_LANE_STB:`LL_LANE_CRED], 0);

    // Both online levels together, count edges after the sampling one
    @(posedge clk_wr);
    #1;
    tx_online = 1'b1;
    rx_online = 1'b1;
    @(posedge clk_wr);
    @(negedge clk_wr);
    cycles  = 0;
    strobes = 0;
    while (!user_m2s_enable) begin
      assert (cycles < TIMEOUT) else fail_now("Timeout waiting for user_m2s_enable");
      // Alignment strobe on lane 0, once and on its own cycle
      if (tx_phy0[`LL_LANE_STB]) begin
        strobes++;
        assert (cycles == DLY_Z) else fail_value("strobe delay in cycles", cycles, DLY_Z);
      end
      @(negedge clk_wr);
      cycles++;
    end
    assert (cycles == DLY_X + DLY_Y + 1)
      else fail_value("user_m2s_enable delay in cycles", cycles, DLY_X + DLY_Y + 1);
    assert (strobes == 1) else fail_value("strobe pulse count", strobes, 1);

    ////////////////////
    // Streaming with the sink always ready

    @(posedge clk_wr);
    #1;
    user_m2s_tready = 1'b1;
    for (int i = 0; i < N_WORDS; i++) begin
      send_word(draw_word());
    end
    wait_drained();
    assert (received == N_WORDS) else fail_value("received word count", received, N_WORDS);
    wait_credit_back();

    // Sink stalled, only the granted credits may pass
    user_m2s_tready = 1'b0;
    user_s2m_tdata  = draw_word();
    user_s2m_tvalid = 1'b1;
    offer_window(STALL_WINDOW, beats);
    assert (beats == int'(INIT_CREDIT))
      else fail_value("beats accepted while stalled", beats, INIT_CREDIT);
    assert (tx_status.stall)
      else fail_value("tx_s2m_debug_status.stall", tx_status.stall, 1);

    // Release the sink, pending word must get through
    user_m2s_tready = 1'b1;
    wait_accept();
    wait_drained();
    wait_credit_back();

    ////////////////////
    // Status words when idle

    assert (int'(tx_status.sent_cnt) == accepted)
      else fail_value("tx_s2m_debug_status.sent_cnt", tx_status.sent_cnt, accepted);
    assert (!tx_status.stall)
      else fail_value("tx_s2m_debug_status.stall", tx_status.stall, 0);
    assert (rx_status.occupancy == '0)
      else fail_value("rx_m2s_debug_status.occupancy", rx_status.occupancy, 0);
    assert (!rx_status.overflow)
      else fail_value("rx_m2s_debug_status.overflow", rx_status.overflow, 0);
    assert (int'(rx_status.recv_cnt) == accepted)
      else fail_value("rx_m2s_debug_status.recv_cnt", rx_status.recv_cnt, accepted);
    assert (received == accepted) else fail_value("received word count", received, accepted);

    if (DUT.props.fail_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_now("A bound protocol assertion failed during the run");
    end
  end

endmodule

// File: verif/st_link_properties.sv
`timescale 1ns/1ps

module st_link_properties (
  input logic             clk_wr,
  input logic             rst_n,
  input logic             tx_online_delay,
  input logic             rx_online_delay,
  input ll_pkg::ll_data_t user_s2m_tdata,
  input logic             user_s2m_tvalid,
  input logic             user_s2m_tready,
  input ll_pkg::ll_data_t user_m2s_tdata,
  input logic             user_m2s_tvalid,
  input logic             user_m2s_tready
);

  // Read back by the testbench at the end of the run
  int unsigned fail_count = 0;

  ////////////////////
  // Stream handshakes

  s2m_valid_hold: assert property (@(posedge clk_wr) disable iff (!rst_n)
    user_s2m_tvalid && !user_s2m_tready |=> user_s2m_tvalid && $stable(user_s2m_tdata))
    else begin
      $error("S2M valid dropped or data changed before the beat");
      fail_count++;
    end

  m2s_valid_hold: assert property (@(posedge clk_wr) disable iff (!rst_n)
    user_m2s_tvalid && !user_m2s_tready |=> user_m2s_tvalid && $stable(user_m2s_tdata))
    else begin
      $error("M2S valid dropped or data changed before the beat");
      fail_count++;
    end

  // No disable here, reset is the condition itself
  // DUT side of both streams stays closed once reset is seen
  no_beat_in_reset: assert property (@(posedge clk_wr)
    !rst_n |=> !user_s2m_tready && !user_m2s_tvalid)
    else begin
      $error("DUT side offered a stream beat during reset");
      fail_count++;
    end

  ////////////////////
  // Online gating

  ready_needs_online: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !(tx_online_delay && rx_online_delay) |-> !user_s2m_tready)
    else begin
      $error("S2M ready high before both online delays expired");
      fail_count++;
    end

endmodule

// File: logic/st_link_slave_top.sv
`timescale 1ns/1ps
`include "ll_defs.svh"

module st_link_slave_top (
  input  logic                  clk_wr,
  input  logic                  rst_n,

  input  logic                  tx_online,
  input  logic                  rx_online,
  input  ll_pkg::ll_cred_t      init_s2m_credit,
  input  logic [`LL_DLY_W-1:0]  delay_x_value,
  input  logic [`LL_DLY_W-1:0]  delay_y_value,
  input  logic [`LL_DLY_W-1:0]  delay_z_value,

  // PHY lanes
  output logic [`LL_LANE_W-1:0] tx_phy0,
  output logic [`LL_LANE_W-1:0] tx_phy1,
  input  logic [`LL_LANE_W-1:0] rx_phy0,
  input  logic [`LL_LANE_W-1:0] rx_phy1,

  // M2S stream to the user
  output ll_pkg::ll_data_t      user_m2s_tdata,
  output logic                  user_m2s_tvalid,
  input  logic                  user_m2s_tready,
  output logic                  user_m2s_enable,

  // S2M stream from the user
  input  ll_pkg::ll_data_t      user_s2m_tdata,
  input  logic                  user_s2m_tvalid,
  output logic                  user_s2m_tready,

  output logic [31:0]           rx_m2s_debug_status,
  output logic [31:0]           tx_s2m_debug_status
);

  logic tx_online_delay;
  logic rx_online_delay;
  logic stb_userbit;

  ll_link_if s2m_link ();
  ll_link_if m2s_link ();

  assign user_m2s_enable = rx_online_delay;

  ////////////////////
  // Online sequencing

  ll_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .stb_userbit     (stb_userbit)
  );

  ////////////////////
  // Link layers

  ll_transmit u_transmit_s2m (
    .clk_wr       (clk_wr),
    .rst_n        (rst_n),
    .tx_online    (tx_online_delay),
    .rx_online    (rx_online_delay),
    .init_credit  (init_s2m_credit),
    .user_data    (user_s2m_tdata),
    .user_valid   (user_s2m_tvalid),
    .user_ready   (user_s2m_tready),
    .debug_status (tx_s2m_debug_status),
    .link         (s2m_link)
  );

  ll_receive u_receive_m2s (
    .clk_wr       (clk_wr),
    .rst_n        (rst_n),
    .rx_online    (rx_online_delay),
    .user_ready   (user_m2s_tready),
    .user_data    (user_m2s_tdata),
    .user_valid   (user_m2s_tvalid),
    .debug_status (rx_m2s_debug_status),
    .link         (m2s_link)
  );

  ////////////////////
  // PHY lane mapping

  ll_phy_concat u_phy_concat (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .stb_userbit (stb_userbit),
    .rx_phy0     (rx_phy0),
    .rx_phy1     (rx_phy1),
    .tx_phy0     (tx_phy0),
    .tx_phy1     (tx_phy1),
    .s2m         (s2m_link),
    .m2s         (m2s_link)
  );

endmodule

// File: logic/ll_phy_concat.sv
`timescale 1ns/1ps
`include "ll_defs.svh"

module ll_phy_concat (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  logic                 stb_userbit,
  input  logic [`LL_LANE_W-1:0] rx_phy0,
  input  logic [`LL_LANE_W-1:0] rx_phy1,
  output logic [`LL_LANE_W-1:0] tx_phy0,
  output logic [`LL_LANE_W-1:0] tx_phy1,
  ll_link_if.phy_tx            s2m,
  ll_link_if.phy_rx            m2s
);

  localparam int HALF_W = `LL_DATA_W / 2;

  ll_pkg::ll_data_t rx_data_q;
  logic             rx_push_q;
  logic             rx_cred_q;

  ////////////////////
  // Pack onto tx lanes

  // Lane 1 holds the upper half of the word
  always_comb begin
    tx_phy0 = '0;
    tx_phy1 = '0;
    tx_phy0[HALF_W-1:0]    = s2m.data[HALF_W-1:0];
    tx_phy0[`LL_LANE_CRED] = m2s.credit;
    tx_phy0[`LL_LANE_PUSH] = s2m.pushbit;
    tx_phy0[`LL_LANE_STB]  = stb_userbit;
    tx_phy1[HALF_W-1:0]    = s2m.data[`LL_DATA_W-1:HALF_W];
  end

  ////////////////////
  // Unpack from rx lanes

  always_ff @(posedge clk_wr) begin
    rx_data_q <= {rx_phy1[HALF_W-1:0], rx_phy0[HALF_W-1:0]};
  end

  // Remote strobe is not consumed on this side
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_push_q <= 1'b0;
      rx_cred_q <= 1'b0;
    end else begin
      rx_push_q <= rx_phy0[`LL_LANE_PUSH];
      rx_cred_q <= rx_phy0[`LL_LANE_CRED];
    end
  end

  assign m2s.data    = rx_data_q;
  assign m2s.pushbit = rx_push_q;
  assign s2m.credit  = rx_cred_q;

endmodule

// File: logic/ll_receive.sv
`timescale 1ns/1ps
`include "ll_defs.svh"

module ll_receive (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  input  logic                  rx_online,
  input  logic                  user_ready,
  output ll_pkg::ll_data_t      user_data,
  output logic                  user_valid,
  output ll_pkg::ll_rx_status_t debug_status,
  ll_link_if.receive            link
);

  localparam int PTR_W = $clog2(`LL_FIFO_DEPTH);

  ll_pkg::ll_data_t mem [`LL_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  ll_pkg::ll_cred_t count;
  ll_pkg::ll_data_t out_data;
  logic             out_valid;
  logic             full;
  logic             wr_req;
  logic             wr_en;
  logic             rd_en;
  logic             pop;
  logic             credit_q;
  logic             overflow_q;
  logic [15:0]      recv_cnt;

  assign full   = count == ll_pkg::ll_cred_t'(`LL_FIFO_DEPTH);
  assign wr_req = link.pushbit && rx_online;
  assign wr_en  = wr_req && !full;
  assign pop    = out_valid && user_ready;

  // Refill the output stage when it is empty or being taken
  assign rd_en = (count != '0) && (!out_valid || pop);

  ////////////////////
  // Storage

  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= link.data;
    end
    if (rd_en) begin
      out_data <= mem[rd_ptr];
    end
  end

  ////////////////////
  // Pointers, output valid, credits

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      out_valid  <= 1'b0;
      credit_q   <= 1'b0;
      overflow_q <= 1'b0;
      recv_cnt   <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr   <= wr_ptr + 1'b1;
        recv_cnt <= recv_cnt + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + ll_pkg::ll_cred_t'(wr_en) - ll_pkg::ll_cred_t'(rd_en);
      if (rd_en) begin
        out_valid <= 1'b1;
      end else if (pop) begin
        out_valid <= 1'b0;
      end
      // One credit back per word handed to the user
      credit_q <= pop;
      if (wr_req && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  assign user_data   = out_data;
  assign user_valid  = out_valid;
  assign link.credit = credit_q;

  assign debug_status.recv_cnt  = recv_cnt;
  assign debug_status.rsvd      = '0;
  assign debug_status.overflow  = overflow_q;
  assign debug_status.occupancy = count + ll_pkg::ll_cred_t'(out_valid);

endmodule

// File: logic/ll_transmit.sv
`timescale 1ns/1ps
`include "ll_defs.svh"

module ll_transmit (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  input  logic                  tx_online,
  input  logic                  rx_online,
  input  ll_pkg::ll_cred_t      init_credit,
  input  ll_pkg::ll_data_t      user_data,
  input  logic                  user_valid,
  output logic                  user_ready,
  output ll_pkg::ll_tx_status_t debug_status,
  ll_link_if.transmit           link
);

  ll_pkg::ll_cred_t credit_q;
  ll_pkg::ll_cred_t init_clamped;
  ll_pkg::ll_data_t data_q;
  logic             pushbit_q;
  logic             tx_online_q;
  logic             tx_rise;
  logic             accept;
  logic             stall_q;
  logic [15:0]      sent_cnt;

  // Far side FIFO bounds the credit grant
  assign init_clamped = (init_credit > ll_pkg::ll_cred_t'(`LL_FIFO_DEPTH)) ?
                        ll_pkg::ll_cred_t'(`LL_FIFO_DEPTH) : init_credit;

  assign tx_rise    = tx_online && !tx_online_q;
  assign user_ready = tx_online && rx_online && (credit_q != '0);
  assign accept     = user_valid && user_ready;

  ////////////////////
  // Credit counter

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_online_q <= 1'b0;
      credit_q    <= '0;
    end else begin
      tx_online_q <= tx_online;
      if (!tx_online) begin
        credit_q <= '0;
      end else if (tx_rise) begin
        credit_q <= init_clamped;
      end else begin
        credit_q <= credit_q + ll_pkg::ll_cred_t'(link.credit) - ll_pkg::ll_cred_t'(accept);
      end
    end
  end

  ////////////////////
  // Link word and status

  always_ff @(posedge clk_wr) begin
    if (accept) begin
      data_q <= user_data;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      pushbit_q <= 1'b0;
      stall_q   <= 1'b0;
      sent_cnt  <= '0;
    end else begin
      pushbit_q <= accept;
      stall_q   <= user_valid && !user_ready;
      if (accept) begin
        sent_cnt <= sent_cnt + 1'b1;
      end
    end
  end

  assign link.data    = data_q;
  assign link.pushbit = pushbit_q;

  assign debug_status.sent_cnt = sent_cnt;
  assign debug_status.rsvd     = '0;
  assign debug_status.stall    = stall_q;
  assign debug_status.credit   = credit_q;

endmodule

// File: logic/ll_auto_sync.sv
`timescale 1ns/1ps
`include "ll_defs.svh"

module ll_auto_sync (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  logic                 tx_online,
  input  logic                 rx_online,
  input  logic [`LL_DLY_W-1:0] delay_x_value,
  input  logic [`LL_DLY_W-1:0] delay_y_value,
  input  logic [`LL_DLY_W-1:0] delay_z_value,
  output logic                 tx_online_delay,
  output logic                 rx_online_delay,
  output logic                 stb_userbit
);

  logic [`LL_DLY_W-1:0] tx_cnt;
  logic [`LL_DLY_W-1:0] rx_cnt;
  logic                 tx_done;
  logic                 rx_done;
  logic                 rx_count_en;
  logic                 stb_hit;

  assign tx_done = tx_cnt >= delay_x_value;
  assign rx_done = rx_cnt >= delay_y_value;

  // rx side only counts once tx is up and both levels hold
  assign rx_count_en = tx_online && rx_online && tx_online_delay;

  // Strobe only if it lands before tx goes online
  assign stb_hit = (tx_cnt == delay_z_value) && (delay_z_value < delay_x_value);

  ////////////////////
  // tx delay and strobe

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online) begin
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
      stb_userbit     <= 1'b0;
    end else begin
      if (!tx_done) begin
        tx_cnt <= tx_cnt + 1'b1;
      end
      tx_online_delay <= tx_done;
      // Counter passes delay_z once, so this is a single pulse
      stb_userbit     <= stb_hit;
    end
  end

  ////////////////////
  // rx delay

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_count_en) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      if (!rx_done) begin
        rx_cnt <= rx_cnt + 1'b1;
      end
      rx_online_delay <= rx_done;
    end
  end

endmodule

// File: logic/ll_link_if.sv
`timescale 1ns/1ps

// Link side of one channel, between a link layer and the PHY packer
interface ll_link_if;

  ll_pkg::ll_data_t data;

  // One cycle per valid word
  logic pushbit;

  // One cycle per returned credit
  logic credit;

  // Link layer sending words
  modport transmit (
    output data,
    output pushbit,
    input  credit
  );

  // Link layer taking words
  modport receive (
    input  data,
    input  pushbit,
    output credit
  );

  // PHY side mirrors of the two link layers
  modport phy_tx (input data, input pushbit, output credit);
  modport phy_rx (output data, output pushbit, input credit);

endinterface

// File: logic/ll_pkg.sv
`include "ll_defs.svh"

package ll_pkg;

  // One stream payload word
  typedef logic [`LL_DATA_W-1:0] ll_data_t;

  // Credit count, wide enough for a full FIFO
  typedef logic [`LL_CRED_W-1:0] ll_cred_t;

  ////////////////////
  // Debug status words

  typedef struct packed {
    logic [15:0] sent_cnt;
    logic [10:0] rsvd;
    logic        stall;
    ll_cred_t    credit;
  } ll_tx_status_t;

  // Occupancy counts the output stage as well
  typedef struct packed {
    logic [15:0] recv_cnt;
    logic [10:0] rsvd;
    logic        overflow;
    ll_cred_t    occupancy;
  } ll_rx_status_t;

endpackage

// File: logic/ll_defs.svh
`ifndef LL_DEFS_SVH
`define LL_DEFS_SVH

// Payload and PHY lane widths
`define LL_DATA_W 32
`define LL_LANE_W 20

// Online delay counter width
`define LL_DLY_W 16

// Receive FIFO depth, also the largest credit grant
`define LL_FIFO_DEPTH 8
`define LL_CRED_W 4

// Control bits carried in lane 0
`define LL_LANE_STB 18
`define LL_LANE_PUSH 17
`define LL_LANE_CRED 16

`endif
